// File: cache_array.sv
// Cache frame storage

`timescale 1ns/1ps

module cache_array #(
    parameter int CACHE_SIZE = 1024,
    parameter int BLOCK_SIZE = 2
) (
    input  logic                                      CLK,
    input  logic                                      nRST,
    input  logic [$clog2(CACHE_SIZE/(4*BLOCK_SIZE))-1:0] rd_idx,
    output logic                                      rd_valid,
    output logic                                      rd_dirty,
    output logic [cache_pkg::WORD_W-$clog2(CACHE_SIZE/4)-3:0] rd_tag,
    output cache_pkg::word_t [BLOCK_SIZE-1:0]         rd_data,
    input  logic                                      we,
    input  logic [$clog2(CACHE_SIZE/(4*BLOCK_SIZE))-1:0] wr_idx,
    input  logic                                      wr_valid,
    input  logic                                      wr_dirty,
    input  logic [cache_pkg::WORD_W-$clog2(CACHE_SIZE/4)-3:0] wr_tag,
    input  cache_pkg::word_t [BLOCK_SIZE-1:0]         wr_data,
    input  logic [cache_pkg::WORD_W*BLOCK_SIZE+cache_pkg::WORD_W-$clog2(CACHE_SIZE/4)-1:0] wr_mask
);

    localparam int N_SETS       = CACHE_SIZE / (4 * BLOCK_SIZE);
    localparam int N_SET_BITS   = $clog2(N_SETS);
    localparam int N_BLOCK_BITS = $clog2(BLOCK_SIZE);
    localparam int TAG_W        = cache_pkg::WORD_W - N_SET_BITS - N_BLOCK_BITS - 2;
    localparam int DATA_W       = cache_pkg::WORD_W * BLOCK_SIZE;
    localparam int FRAME_W      = DATA_W + TAG_W + 2;   // {valid, dirty, tag, data}

    logic [N_SETS-1:0]                 valid;
    logic [N_SETS-1:0]                 dirty;
    logic [TAG_W-1:0]                  tag_mem  [N_SETS];
    cache_pkg::word_t [BLOCK_SIZE-1:0] data_mem [N_SETS];

    logic [TAG_W-1:0]  tag_m;
    logic [DATA_W-1:0] data_m;

    assign tag_m  = wr_mask[DATA_W +: TAG_W];
    assign data_m = wr_mask[DATA_W-1:0];

    // asynchronous read port
    assign rd_valid = valid[rd_idx];
    assign rd_dirty = dirty[rd_idx];
    assign rd_tag   = tag_mem[rd_idx];
    assign rd_data  = data_mem[rd_idx];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid <= '0;
            dirty <= '0;
        end else if (we) begin
            if (wr_mask[FRAME_W-1]) valid[wr_idx] <= wr_valid;
            if (wr_mask[FRAME_W-2]) dirty[wr_idx] <= wr_dirty;
        end
    end

    // only the masked bits of tag and data change
    always_ff @(posedge CLK) begin
        if (we) begin
            tag_mem[wr_idx]  <= (tag_mem[wr_idx] & ~tag_m) | (wr_tag & tag_m);
            data_mem[wr_idx] <= (data_mem[wr_idx] & ~data_m) | (wr_data & data_m);
        end
    end

endmodule

// File: cache_controller.sv
// Cache controller FSM

`timescale 1ns/1ps

module cache_controller #(
    parameter int CACHE_SIZE = 1024,
    parameter int BLOCK_SIZE = 2
) (
    input  logic                                      CLK,
    input  logic                                      nRST,
    input  cache_pkg::proc_req_t                      proc_req,
    input  logic                                      flush,
    output logic                                      flush_done,
    input  logic                                      hit,
    input  logic                                      pass_through,
    input  logic [$clog2(CACHE_SIZE/(4*BLOCK_SIZE))-1:0] set_idx,
    input  logic [$clog2(BLOCK_SIZE)-1:0]             word_off,
    input  logic                                      rd_valid,
    input  logic                                      rd_dirty,
    input  logic [cache_pkg::WORD_W-$clog2(CACHE_SIZE/4)-3:0] rd_tag,
    input  cache_pkg::word_t [BLOCK_SIZE-1:0]         rd_data,
    input  cache_pkg::word_t                          hit_word,
    input  cache_pkg::word_t                          lane_mask,
    input  cache_pkg::word_t                          lane_data,
    output cache_pkg::proc_rsp_t                      proc_rsp,
    output cache_pkg::mem_req_t                       mem_req,
    input  cache_pkg::mem_rsp_t                       mem_rsp,
    output logic [$clog2(CACHE_SIZE/(4*BLOCK_SIZE))-1:0] rd_idx,
    output logic                                      we,
    output logic [$clog2(CACHE_SIZE/(4*BLOCK_SIZE))-1:0] wr_idx,
    output logic                                      wr_valid,
    output logic                                      wr_dirty,
    output logic [cache_pkg::WORD_W-$clog2(CACHE_SIZE/4)-3:0] wr_tag,
    output cache_pkg::word_t [BLOCK_SIZE-1:0]         wr_data,
    output logic [cache_pkg::WORD_W*BLOCK_SIZE+cache_pkg::WORD_W-$clog2(CACHE_SIZE/4)-1:0] wr_mask
);

    localparam int N_SETS       = CACHE_SIZE / (4 * BLOCK_SIZE);
    localparam int N_SET_BITS   = $clog2(N_SETS);
    localparam int N_BLOCK_BITS = $clog2(BLOCK_SIZE);
    localparam int TAG_W        = cache_pkg::WORD_W - N_SET_BITS - N_BLOCK_BITS - 2;
    localparam int BLK_W        = TAG_W + N_SET_BITS;
    localparam int WCNT_W       = N_BLOCK_BITS + 1;
    localparam int SCNT_W       = N_SET_BITS + 1;

    cache_pkg::cache_state_t state, state_next;

    logic [WCNT_W-1:0]       word_cnt, word_cnt_next;
    logic [SCNT_W-1:0]       set_cnt, set_cnt_next;
    logic [BLK_W-1:0]        blk_addr, blk_addr_next;   // {tag, index} of the block in flight
    logic [N_BLOCK_BITS-1:0] word_idx;
    logic [TAG_W-1:0]        req_tag;
    logic                    req;
    logic                    word_done;
    logic                    scan_done;
    logic                    flushing;

    // write mask fields, packed into wr_mask below
    logic                              mask_valid;
    logic                              mask_dirty;
    logic                              mask_tag;
    cache_pkg::word_t [BLOCK_SIZE-1:0] data_mask;

    assign req       = proc_req.ren | proc_req.wen;
    assign req_tag   = proc_req.addr[cache_pkg::WORD_W-1 -: TAG_W];
    assign word_idx  = word_cnt[N_BLOCK_BITS-1:0];
    assign word_done = (word_cnt == WCNT_W'(BLOCK_SIZE));
    assign scan_done = (set_cnt == SCNT_W'(N_SETS));
    assign flushing  = (state == cache_pkg::FLUSH_SCAN) || (state == cache_pkg::FLUSH_WB);

    // the flush walks the sets, otherwise the request picks the set
    assign rd_idx  = flushing ? set_cnt[N_SET_BITS-1:0] : set_idx;
    assign wr_idx  = rd_idx;
    assign wr_mask = {mask_valid, mask_dirty, {TAG_W{mask_tag}}, data_mask};

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= cache_pkg::IDLE;
            word_cnt <= '0;
            set_cnt  <= '0;
        end else begin
            state    <= state_next;
            word_cnt <= word_cnt_next;
            set_cnt  <= set_cnt_next;
        end
    end

    always_ff @(posedge CLK) begin
        blk_addr <= blk_addr_next;
    end

    always_comb begin
        state_next      = state;
        word_cnt_next   = word_cnt;
        set_cnt_next    = set_cnt;
        blk_addr_next   = blk_addr;
        flush_done      = 1'b0;

        proc_rsp.busy   = 1'b1;
        proc_rsp.rdata  = hit_word;

        mem_req.ren     = 1'b0;
        mem_req.wen     = 1'b0;
        mem_req.addr    = {blk_addr, word_idx, 2'b00};
        mem_req.wdata   = rd_data[word_idx];   // write-back source
        mem_req.byte_en = 4'b1111;

        we              = 1'b0;
        wr_valid        = 1'b0;
        wr_dirty        = 1'b0;
        wr_tag          = req_tag;
        wr_data         = '0;
        mask_valid      = 1'b0;
        mask_dirty      = 1'b0;
        mask_tag        = 1'b0;
        data_mask       = '0;

        case (state)
            cache_pkg::IDLE: begin
                if (!req) begin
                    if (flush) begin
                        set_cnt_next = '0;
                        state_next   = cache_pkg::FLUSH_SCAN;
                    end
                end else if (pass_through) begin
                    mem_req.ren     = proc_req.ren;
                    mem_req.wen     = proc_req.wen;
                    mem_req.addr    = proc_req.addr;
                    mem_req.wdata   = lane_data;
                    mem_req.byte_en = proc_req.byte_en;
                    proc_rsp.busy   = mem_rsp.busy;
                    proc_rsp.rdata  = mem_rsp.rdata;
                end else if (hit) begin
                    proc_rsp.busy = 1'b0;
                    if (proc_req.wen) begin
                        we                  = 1'b1;
                        wr_dirty            = 1'b1;
                        mask_dirty          = 1'b1;
                        wr_data[word_off]   = lane_data;
                        data_mask[word_off] = lane_mask;
                    end
                end else if (rd_valid && rd_dirty) begin
                    blk_addr_next = {rd_tag, set_idx};   // victim goes out first
                    state_next    = cache_pkg::WB;
                end else begin
                    blk_addr_next = {req_tag, set_idx};
                    state_next    = cache_pkg::FETCH;
                end
            end

            cache_pkg::FETCH: begin
                mem_req.ren = !word_done;
                if (word_done) begin
                    // all words in, now claim the frame
                    we            = 1'b1;
                    wr_valid      = 1'b1;
                    mask_valid    = 1'b1;
                    mask_dirty    = 1'b1;
                    mask_tag      = 1'b1;
                    word_cnt_next = '0;
                    state_next    = cache_pkg::IDLE;
                end else if (!mem_rsp.busy) begin
                    we                  = 1'b1;
                    wr_data[word_idx]   = mem_rsp.rdata;
                    data_mask[word_idx] = '1;
                    word_cnt_next       = word_cnt + 1'b1;
                end
            end

            cache_pkg::WB, cache_pkg::FLUSH_WB: begin
                mem_req.wen = !word_done;
                if (word_done) begin
                    we            = 1'b1;
                    mask_dirty    = 1'b1;   // clean after write-back
                    word_cnt_next = '0;
                    if (state == cache_pkg::WB) begin
                        blk_addr_next = {req_tag, set_idx};
                        state_next    = cache_pkg::FETCH;
                    end else begin
                        mask_valid   = 1'b1;   // flush also drops the frame
                        set_cnt_next = set_cnt + 1'b1;
                        state_next   = cache_pkg::FLUSH_SCAN;
                    end
                end else if (!mem_rsp.busy) begin
                    word_cnt_next = word_cnt + 1'b1;
                end
            end

            cache_pkg::FLUSH_SCAN: begin
                if (scan_done) begin
                    flush_done = 1'b1;
                    state_next = cache_pkg::IDLE;
                end else if (rd_valid && rd_dirty) begin
                    blk_addr_next = {rd_tag, set_cnt[N_SET_BITS-1:0]};
                    state_next    = cache_pkg::FLUSH_WB;
                end else begin
                    we           = 1'b1;   // invalidate clean or empty set
                    mask_valid   = 1'b1;
                    mask_dirty   = 1'b1;
                    set_cnt_next = set_cnt + 1'b1;
                end
            end

            default: state_next = cache_pkg::IDLE;
        endcase
    end

endmodule

// File: cache_lookup.sv
// Address decode and hit logic

`timescale 1ns/1ps

module cache_lookup #(
    parameter int               CACHE_SIZE          = 1024,
    parameter int               BLOCK_SIZE          = 2,
    parameter cache_pkg::word_t NONCACHE_START_ADDR = 32'h8000_0000
) (
    input  cache_pkg::proc_req_t                      proc_req,
    input  logic                                      rd_valid,
    input  logic [cache_pkg::WORD_W-$clog2(CACHE_SIZE/4)-3:0] rd_tag,
    input  cache_pkg::word_t [BLOCK_SIZE-1:0]         rd_data,
    output logic [$clog2(CACHE_SIZE/(4*BLOCK_SIZE))-1:0] set_idx,
    output logic [$clog2(BLOCK_SIZE)-1:0]             word_off,
    output logic                                      hit,
    output logic                                      pass_through,
    output cache_pkg::word_t                          hit_word,
    output cache_pkg::word_t                          lane_mask,
    output cache_pkg::word_t                          lane_data
);

    localparam int N_SETS       = CACHE_SIZE / (4 * BLOCK_SIZE);
    localparam int N_SET_BITS   = $clog2(N_SETS);
    localparam int N_BLOCK_BITS = $clog2(BLOCK_SIZE);
    localparam int TAG_W        = cache_pkg::WORD_W - N_SET_BITS - N_BLOCK_BITS - 2;

    logic [TAG_W-1:0] req_tag;

    // addr = {tag, index, word offset, byte}
    assign req_tag  = proc_req.addr[cache_pkg::WORD_W-1 -: TAG_W];
    assign set_idx  = proc_req.addr[N_BLOCK_BITS+2 +: N_SET_BITS];
    assign word_off = proc_req.addr[2 +: N_BLOCK_BITS];

    // uncached region bypasses the array entirely
    assign pass_through = (proc_req.addr >= NONCACHE_START_ADDR);
    assign hit          = !pass_through && rd_valid && (rd_tag == req_tag);

    assign hit_word = rd_data[word_off];

    // byte_en to bit mask, odd patterns write the whole word
    always_comb begin
        case (proc_req.byte_en)
            4'b0001: lane_mask = 32'h0000_00ff;
            4'b0010: lane_mask = 32'h0000_ff00;
            4'b0100: lane_mask = 32'h00ff_0000;
            4'b1000: lane_mask = 32'hff00_0000;
            4'b0011: lane_mask = 32'h0000_ffff;   // lower half
            4'b1100: lane_mask = 32'hffff_0000;   // upper half
            default: lane_mask = 32'hffff_ffff;
        endcase
    end

    // data stays in its own lanes, the rest is zero
    assign lane_data = proc_req.wdata & lane_mask;

endmodule

// File: cache_pkg.sv
// L1 cache shared types

package cache_pkg;

    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [3:0]        byte_en_t;   // one bit per byte lane

    // processor side
    typedef struct packed {
        logic     ren;
        logic     wen;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } proc_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } proc_rsp_t;

    // memory side, same layout as the processor bus
    typedef struct packed {
        logic     ren;
        logic     wen;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } mem_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } mem_rsp_t;

    // controller FSM
    typedef enum logic [2:0] {
        IDLE,
        FETCH,       // block read from memory
        WB,          // dirty victim write-back before a fetch
        FLUSH_SCAN,  // one set per cycle
        FLUSH_WB     // write-back of a dirty set during flush
    } cache_state_t;

endpackage

// File: l1_cache.sv
// Direct-mapped L1 data cache

`timescale 1ns/1ps

module l1_cache #(
    parameter int               CACHE_SIZE          = 1024,   // bytes, power of two
    parameter int               BLOCK_SIZE          = 2,      // words per frame, 2 to 8
    parameter cache_pkg::word_t NONCACHE_START_ADDR = 32'h8000_0000
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 flush,
    output logic                 flush_done,
    input  cache_pkg::proc_req_t proc_req,
    output cache_pkg::proc_rsp_t proc_rsp,
    output cache_pkg::mem_req_t  mem_req,
    input  cache_pkg::mem_rsp_t  mem_rsp
);

    localparam int N_SETS       = CACHE_SIZE / (4 * BLOCK_SIZE);
    localparam int N_SET_BITS   = $clog2(N_SETS);
    localparam int N_BLOCK_BITS = $clog2(BLOCK_SIZE);
    localparam int TAG_W        = cache_pkg::WORD_W - N_SET_BITS - N_BLOCK_BITS - 2;
    localparam int FRAME_W      = cache_pkg::WORD_W * BLOCK_SIZE + TAG_W + 2;

    // array read side
    logic [N_SET_BITS-1:0]             rd_idx;
    logic                              rd_valid;
    logic                              rd_dirty;
    logic [TAG_W-1:0]                  rd_tag;
    cache_pkg::word_t [BLOCK_SIZE-1:0] rd_data;

    // array write side
    logic                              we;
    logic [N_SET_BITS-1:0]             wr_idx;
    logic                              wr_valid;
    logic                              wr_dirty;
    logic [TAG_W-1:0]                  wr_tag;
    cache_pkg::word_t [BLOCK_SIZE-1:0] wr_data;
    logic [FRAME_W-1:0]                wr_mask;

    // lookup results
    logic [N_SET_BITS-1:0]   set_idx;
    logic [N_BLOCK_BITS-1:0] word_off;
    logic                    hit;
    logic                    pass_through;
    cache_pkg::word_t        hit_word;
    cache_pkg::word_t        lane_mask;
    cache_pkg::word_t        lane_data;

    cache_array #(
        .CACHE_SIZE(CACHE_SIZE),
        .BLOCK_SIZE(BLOCK_SIZE)
    ) i_array (
        .CLK(CLK), .nRST(nRST),
        .rd_idx(rd_idx), .rd_valid(rd_valid), .rd_dirty(rd_dirty),
        .rd_tag(rd_tag), .rd_data(rd_data),
        .we(we), .wr_idx(wr_idx), .wr_valid(wr_valid), .wr_dirty(wr_dirty),
        .wr_tag(wr_tag), .wr_data(wr_data), .wr_mask(wr_mask)
    );

    cache_lookup #(
        .CACHE_SIZE(CACHE_SIZE),
        .BLOCK_SIZE(BLOCK_SIZE),
        .NONCACHE_START_ADDR(NONCACHE_START_ADDR)
    ) i_lookup (
        .proc_req(proc_req),
        .rd_valid(rd_valid), .rd_tag(rd_tag), .rd_data(rd_data),
        .set_idx(set_idx), .word_off(word_off),
        .hit(hit), .pass_through(pass_through),
        .hit_word(hit_word), .lane_mask(lane_mask), .lane_data(lane_data)
    );

    cache_controller #(
        .CACHE_SIZE(CACHE_SIZE),
        .BLOCK_SIZE(BLOCK_SIZE)
    ) i_ctrl (
        .CLK(CLK), .nRST(nRST),
        .proc_req(proc_req), .flush(flush), .flush_done(flush_done),
        .hit(hit), .pass_through(pass_through),
        .set_idx(set_idx), .word_off(word_off),
        .rd_valid(rd_valid), .rd_dirty(rd_dirty), .rd_tag(rd_tag), .rd_data(rd_data),
        .hit_word(hit_word), .lane_mask(lane_mask), .lane_data(lane_data),
        .proc_rsp(proc_rsp), .mem_req(mem_req), .mem_rsp(mem_rsp),
        .rd_idx(rd_idx), .we(we), .wr_idx(wr_idx),
        .wr_valid(wr_valid), .wr_dirty(wr_dirty), .wr_tag(wr_tag),
        .wr_data(wr_data), .wr_mask(wr_mask)
    );

endmodule

// File: tb_checker.sv
// Cache scoreboard

`timescale 1ns/1ps

module tb_checker #(
    parameter cache_pkg::word_t NC_BASE = 32'h8000_0000
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 flush_done,
    input  cache_pkg::proc_req_t proc_req,
    input  cache_pkg::proc_rsp_t proc_rsp,
    input  cache_pkg::mem_req_t  mem_req,
    input  cache_pkg::mem_rsp_t  mem_rsp,
    output int                   err_cnt,
    output int                   chk_cnt
);

    cache_pkg::word_t shadow  [2048];   // memory as the processor should see it
    cache_pkg::word_t mem_img [2048];   // what actually reached the memory bus
    logic             written [2048];
    logic             cold    [2048];   // not fetched since reset or the last flush
    logic             seen_req;

    function automatic cache_pkg::word_t fill_word(input cache_pkg::word_t addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic int word_index(input cache_pkg::word_t a);
        return {a[31], a[11:2]};
    endfunction

    // bits that a write may change
    function automatic cache_pkg::word_t lanes(input cache_pkg::byte_en_t be);
        case (be)
            4'b0001: return 32'h0000_00ff;
            4'b0010: return 32'h0000_ff00;
            4'b0100: return 32'h00ff_0000;
            4'b1000: return 32'hff00_0000;
            4'b0011: return 32'h0000_ffff;
            4'b1100: return 32'hffff_0000;
            default: return 32'hffff_ffff;   // odd enables mean the whole word
        endcase
    endfunction

    // reference model of one write
    function automatic cache_pkg::word_t merge_write(input cache_pkg::word_t old,
                                                     input cache_pkg::word_t wdata,
                                                     input cache_pkg::byte_en_t be);
        return (old & ~lanes(be)) | (wdata & lanes(be));
    endfunction

    task automatic log_fail(input string msg);
        err_cnt++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    initial begin
        err_cnt  = 0;
        chk_cnt  = 0;
        seen_req = 1'b0;
        for (int i = 0; i < 2048; i++) begin
            shadow[i]  = fill_word({i[10], 19'd0, i[9:0], 2'b00});
            mem_img[i] = shadow[i];
            written[i] = 1'b0;
            cold[i]    = 1'b1;   // every frame starts invalid
        end
    end

    // sampled mid-cycle when all signals have settled
    always @(negedge CLK) begin
        int               idx;
        int               mi;
        cache_pkg::word_t exp;
        if (nRST) begin
            idx = word_index(proc_req.addr);
            mi  = word_index(mem_req.addr);
            if (proc_req.ren || proc_req.wen) begin
                seen_req = 1'b1;
            end else if (!seen_req) begin
                chk_cnt++;
                if (mem_req.ren || mem_req.wen || flush_done)
                    log_fail("memory strobe or flush_done high before any request");
            end
            if ((proc_req.ren || proc_req.wen) && proc_req.addr >= NC_BASE) begin
                chk_cnt++;
                exp = proc_req.wdata & lanes(proc_req.byte_en);
                if (mem_req.ren !== proc_req.ren || mem_req.wen !== proc_req.wen ||
                        mem_req.addr !== proc_req.addr || mem_req.byte_en !== proc_req.byte_en ||
                        mem_req.wdata !== exp)
                    log_fail($sformatf("uncached access 0x%08h not copied to mem_req",
                                       proc_req.addr));
                if (proc_rsp !== mem_rsp)
                    log_fail($sformatf("uncached access 0x%08h, proc_rsp differs from mem_rsp",
                                       proc_req.addr));
            end
            if (mem_req.ren && !mem_rsp.busy && mem_req.addr < NC_BASE)
                cold[mi] = 1'b0;   // word refetched into a frame
            if (mem_req.wen && !mem_rsp.busy) begin
                if (mem_req.addr < NC_BASE) begin
                    chk_cnt++;
                    if (mem_req.wdata !== shadow[mi])
                        log_fail($sformatf("memory write 0x%08h data 0x%08h, expected 0x%08h",
                                           mem_req.addr, mem_req.wdata, shadow[mi]));
                end
                mem_img[mi] = merge_write(mem_img[mi], mem_req.wdata, mem_req.byte_en);
            end
            if ((proc_req.ren || proc_req.wen) && !proc_rsp.busy &&
                    proc_req.addr < NC_BASE) begin
                chk_cnt++;
                if (cold[idx])
                    log_fail($sformatf("access 0x%08h served from an invalidated frame",
                                       proc_req.addr));
            end
            if (proc_req.ren && !proc_rsp.busy) begin
                chk_cnt++;
                if (proc_rsp.rdata !== shadow[idx])
                    log_fail($sformatf("read 0x%08h returned 0x%08h, expected 0x%08h",
                                       proc_req.addr, proc_rsp.rdata, shadow[idx]));
            end
            if (proc_req.wen && !proc_rsp.busy) begin
                shadow[idx] = merge_write(shadow[idx], proc_req.wdata, proc_req.byte_en);
                if (proc_req.addr < NC_BASE)
                    written[idx] = 1'b1;
            end
            if (flush_done) begin
                for (int i = 0; i < 1024; i++) begin
                    cold[i] = 1'b1;
                    if (written[i]) begin
                        chk_cnt++;
                        if (mem_img[i] !== shadow[i])
                            log_fail($sformatf("after flush 0x%08h holds 0x%08h, expected 0x%08h",
                                               {20'd0, i[9:0], 2'b00}, mem_img[i], shadow[i]));
                    end
                end
            end
        end
    end

endmodule

// File: tb_l1_cache.sv
// L1 cache testbench

`timescale 1ns/1ps

module tb_l1_cache;

    localparam int               CACHE_SIZE  = 1024;
    localparam int               BLOCK_SIZE  = 2;
    localparam cache_pkg::word_t NC_BASE     = 32'h8000_0000;
    localparam int               N_SETS      = CACHE_SIZE / (4 * BLOCK_SIZE);
    localparam int               N_OPS       = 400;
    localparam int               FLUSH_EVERY = 100;
    // worst case per access and per flush, plus reset and closing cycles
    localparam int               MAX_CYCLES  = N_OPS * (2 * BLOCK_SIZE * 4 + 8)
                                             + 4 * (N_SETS * (BLOCK_SIZE * 4 + 3)) + 10;

    logic                 CLK;
    logic                 nRST;
    logic                 flush;
    logic                 flush_done;
    cache_pkg::proc_req_t proc_req;
    cache_pkg::proc_rsp_t proc_rsp;
    cache_pkg::mem_req_t  mem_req;
    cache_pkg::mem_rsp_t  mem_rsp;

    cache_pkg::word_t mem [2048];   // indexed by {addr[31], addr[11:2]}
    logic [1:0]       wait_left;    // busy cycles left for the current word
    logic             mem_busy;
    cache_pkg::word_t mem_rdata;
    logic [31:0]      lfsr_stim;
    logic [31:0]      lfsr_mem;
    int               cycles;
    int               err_cnt;
    int               chk_cnt;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32, 22, 2, 1
    endfunction

    task automatic take_bits(input int n, inout logic [31:0] st, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            st  = lfsr_next(st);
            val = {val[30:0], st[0]};
        end
    endtask

    function automatic cache_pkg::word_t fill_word(input cache_pkg::word_t addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    task automatic random_access();
        logic [31:0]          r;
        cache_pkg::proc_req_t req;
        take_bits(3, lfsr_stim, r);
        req.addr = (r[2:0] == 3'd0) ? NC_BASE : 32'h0;   // one in eight uncached
        take_bits(6, lfsr_stim, r);
        req.addr[11:10] = r[5:4];   // four tags
        req.addr[5:2]   = r[3:0];   // eight sets, word offset
        take_bits(1, lfsr_stim, r);
        req.ren = !r[0];
        req.wen = r[0];
        take_bits(32, lfsr_stim, r);
        req.wdata = r;
        take_bits(3, lfsr_stim, r);
        case (r[2:0])
            3'd0:    req.byte_en = 4'b0001;
            3'd1:    req.byte_en = 4'b0010;
            3'd2:    req.byte_en = 4'b0100;
            3'd3:    req.byte_en = 4'b1000;
            3'd4:    req.byte_en = 4'b0011;
            3'd5:    req.byte_en = 4'b1100;
            default: req.byte_en = 4'b1111;
        endcase
        proc_req <= req;
        do @(posedge CLK); while (proc_rsp.busy);   // held until accepted
    endtask

    task automatic run_flush();
        proc_req <= '0;
        flush    <= 1'b1;
        do @(posedge CLK); while (!flush_done);
        flush <= 1'b0;
    endtask

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // memory model, 0 to 3 busy cycles per word
    assign mem_busy  = (wait_left != 2'd0);
    assign mem_rdata = mem[{mem_req.addr[31], mem_req.addr[11:2]}];
    assign mem_rsp   = {mem_busy, mem_rdata};

    always @(posedge CLK) begin
        logic [31:0] r;
        if (mem_req.ren || mem_req.wen) begin
            if (!mem_busy) begin
                if (mem_req.wen) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_req.byte_en[b])
                            mem[{mem_req.addr[31], mem_req.addr[11:2]}][8*b +: 8]
                                <= mem_req.wdata[8*b +: 8];
                    end
                end
                take_bits(2, lfsr_mem, r);
                wait_left <= r[1:0];
            end else begin
                wait_left <= wait_left - 1'b1;
            end
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the cache stopped answering", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        int n;
        for (int i = 0; i < 2048; i++)
            mem[i] = fill_word({i[10], 19'd0, i[9:0], 2'b00});
        lfsr_stim = 32'h7c03eafd;
        lfsr_mem  = 32'h7c03eafd;
        wait_left = 2'd0;
        cycles    = 0;
        nRST      = 1'b0;
        flush     = 1'b0;
        proc_req  = '0;
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;
        repeat (2) @(posedge CLK);   // quiet cycles before the first request
        for (n = 0; n < N_OPS; n++) begin
            random_access();
            if (n % FLUSH_EVERY == FLUSH_EVERY - 1)
                run_flush();
        end
        proc_req <= '0;
        repeat (2) @(posedge CLK);
        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    l1_cache #(
        .CACHE_SIZE(CACHE_SIZE),
        .BLOCK_SIZE(BLOCK_SIZE),
        .NONCACHE_START_ADDR(NC_BASE)
    ) i_dut (
        .CLK(CLK), .nRST(nRST),
        .flush(flush), .flush_done(flush_done),
        .proc_req(proc_req), .proc_rsp(proc_rsp),
        .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    tb_checker #(
        .NC_BASE(NC_BASE)
    ) i_chk (
        .CLK(CLK), .nRST(nRST), .flush_done(flush_done),
        .proc_req(proc_req), .proc_rsp(proc_rsp),
        .mem_req(mem_req), .mem_rsp(mem_rsp),
        .err_cnt(err_cnt), .chk_cnt(chk_cnt)
    );

endmodule

// File: vlog.f
cache_pkg.sv
cache_array.sv
cache_lookup.sv
cache_controller.sv
l1_cache.sv
tb_checker.sv
tb_l1_cache.sv
